// ==== dataPath_config.svh ====
`ifndef DATAPATH_CONFIG_SVH
`define DATAPATH_CONFIG_SVH

// register and bus width
`define DP_DATA_WIDTH 32

// size of the register file
`define DP_REG_COUNT 32

// bits in a register number
`define DP_REG_ADDR_WIDTH 5

`endif

// ==== dataPathPkg.sv ====
`include "dataPath_config.svh"

package dataPathPkg;

  typedef logic [`DP_DATA_WIDTH-1:0] word_t;
  typedef logic [`DP_REG_ADDR_WIDTH-1:0] regAddr_t;

  // one select bit per byte lane
  typedef logic [`DP_DATA_WIDTH/8-1:0] byteSel_t;

  // encoding 2'b11 is unused and handled like a word
  typedef enum logic [1:0] {
    sizeByte = 2'b00,
    sizeHalf = 2'b01,
    sizeWord = 2'b10
  } accSize_t;

  typedef enum logic [1:0] {
    opWrite = 2'b00,
    opRead  = 2'b01,
    opLoad  = 2'b10,
    opStore = 2'b11
  } cmdOp_t;

  typedef enum logic [1:0] {
    stIdle,
    stReadRegs,
    stBusCycle,
    stFinish
  } ctrlState_t;

endpackage

// ==== regPortIf.sv ====
interface regPortIf;

  // read addresses, A and B are operands, D is the store source
  dataPathPkg::regAddr_t readAddrA;
  dataPathPkg::regAddr_t readAddrB;
  dataPathPkg::regAddr_t readAddrD;

  // registered read data, one cycle behind the address
  dataPathPkg::word_t readDataA;
  dataPathPkg::word_t readDataB;
  dataPathPkg::word_t readDataD;

  logic writeEnable;
  dataPathPkg::regAddr_t writeAddr;
  dataPathPkg::word_t writeData;

  modport ctrl (
    output readAddrA, readAddrB, readAddrD,
    output writeEnable, writeAddr, writeData,
    input  readDataA, readDataB, readDataD
  );

  modport rf (
    input  readAddrA, readAddrB, readAddrD,
    input  writeEnable, writeAddr, writeData,
    output readDataA, readDataB, readDataD
  );

endinterface

// ==== regFile.sv ====
`include "dataPath_config.svh"

module regFile (
  input logic  gclk,
  input logic  reset,
  regPortIf.rf regs
);

  dataPathPkg::word_t regArray [`DP_REG_COUNT];

  // value seen by a read port in this cycle
  function automatic dataPathPkg::word_t readPort(input dataPathPkg::regAddr_t addr);
    dataPathPkg::word_t value;
    if (addr == '0) begin
      value = '0;
    end else if (regs.writeEnable && (regs.writeAddr == addr)) begin
      // same-cycle write is passed straight through
      value = regs.writeData;
    end else begin
      value = regArray[addr];
    end
    return value;
  endfunction

  // register 0 is never stored
  always_ff @(posedge gclk) begin
    if (regs.writeEnable && (regs.writeAddr != '0)) begin
      regArray[regs.writeAddr] <= regs.writeData;
    end
  end

  always_ff @(posedge gclk) begin
    if (reset) begin
      regs.readDataA <= '0;
      regs.readDataB <= '0;
      regs.readDataD <= '0;
    end else begin
      regs.readDataA <= readPort(regs.readAddrA);
      regs.readDataB <= readPort(regs.readAddrB);
      regs.readDataD <= readPort(regs.readAddrD);
    end
  end

  // register 0 read on any port gives zero in the next cycle
  property zeroReg(addr, data);
    @(posedge gclk) disable iff (reset) (addr == '0) |=> (data == '0);
  endproperty

  zeroRegA: assert property (zeroReg(regs.readAddrA, regs.readDataA));
  zeroRegB: assert property (zeroReg(regs.readAddrB, regs.readDataB));
  zeroRegD: assert property (zeroReg(regs.readAddrD, regs.readDataD));

endmodule

// ==== loadAlign.sv ====
`include "dataPath_config.svh"

module loadAlign (
  input  dataPathPkg::word_t    dataIn,
  input  logic [1:0]            addrLow,
  input  dataPathPkg::accSize_t size,
  output dataPathPkg::word_t    dataOut
);

  logic [7:0] byteLane;
  logic [15:0] halfLane;

  // lane picked by the low address bits
  assign byteLane = dataIn[{addrLow, 3'b000} +: 8];

  // upper or lower half, bit 0 is already checked by the store aligner
  assign halfLane = dataIn[{addrLow[1], 4'b0000} +: 16];

  always_comb begin
    case (size)
      dataPathPkg::sizeByte: begin
        dataOut = {{(`DP_DATA_WIDTH-8){1'b0}}, byteLane};
      end
      dataPathPkg::sizeHalf: begin
        dataOut = {{(`DP_DATA_WIDTH-16){1'b0}}, halfLane};
      end
      default: begin
        dataOut = dataIn;
      end
    endcase
  end

endmodule

// ==== storeAlign.sv ====
`include "dataPath_config.svh"

module storeAlign (
  input  dataPathPkg::word_t    dataIn,
  input  logic [1:0]            addrLow,
  input  dataPathPkg::accSize_t size,
  output dataPathPkg::word_t    dataOut,
  output dataPathPkg::byteSel_t byteSel,
  output logic                  misaligned
);

  always_comb begin
    case (size)
      dataPathPkg::sizeByte: begin
        // same byte on every lane, one lane selected
        dataOut    = {(`DP_DATA_WIDTH/8){dataIn[7:0]}};
        byteSel    = dataPathPkg::byteSel_t'(1) << addrLow;
        misaligned = 1'b0;
      end
      dataPathPkg::sizeHalf: begin
        dataOut    = {(`DP_DATA_WIDTH/16){dataIn[15:0]}};
        byteSel    = addrLow[1] ? 4'b1100 : 4'b0011;
        // odd address
        misaligned = addrLow[0];
      end
      default: begin
        dataOut    = dataIn;
        byteSel    = '1;
        misaligned = (addrLow != 2'b00);
      end
    endcase
  end

endmodule

// ==== dataPathControl.sv ====
`include "dataPath_config.svh"

module dataPathControl (
  input  logic                  gclk,
  input  logic                  reset,
  input  logic                  cmdValid,
  input  dataPathPkg::cmdOp_t   cmdOp,
  input  dataPathPkg::accSize_t cmdSize,
  input  dataPathPkg::regAddr_t cmdRd,
  input  dataPathPkg::regAddr_t cmdRa,
  input  dataPathPkg::regAddr_t cmdRb,
  input  dataPathPkg::word_t    cmdData,
  output logic                  cmdReady,
  output logic                  doneValid,
  output logic                  doneError,
  output dataPathPkg::word_t    resultA,
  output dataPathPkg::word_t    resultB,
  output logic                  wbCyc,
  output logic                  wbStb,
  output logic                  wbWe,
  output dataPathPkg::word_t    wbAdr,
  output dataPathPkg::byteSel_t wbSel,
  output dataPathPkg::word_t    wbDatOut,
  input  logic                  wbAck,
  regPortIf.ctrl                regs,
  input  dataPathPkg::word_t    storeData,
  input  dataPathPkg::byteSel_t storeSel,
  input  logic                  misaligned,
  input  dataPathPkg::word_t    loadData,
  output dataPathPkg::word_t    accAddr,
  output dataPathPkg::accSize_t accSize
);

  dataPathPkg::ctrlState_t state;
  dataPathPkg::cmdOp_t opReg;
  dataPathPkg::regAddr_t rdReg;
  dataPathPkg::regAddr_t raReg;
  dataPathPkg::regAddr_t rbReg;
  dataPathPkg::word_t dataReg;
  dataPathPkg::word_t sumAddr;

  assign cmdReady  = (state == dataPathPkg::stIdle);
  assign doneValid = (state == dataPathPkg::stFinish);

  // addresses follow the command while idle, so data is there right after accept
  assign regs.readAddrA = cmdReady ? cmdRa : raReg;
  assign regs.readAddrB = cmdReady ? cmdRb : rbReg;
  assign regs.readAddrD = cmdReady ? cmdRd : rdReg;

  // register A plus offset
  assign sumAddr = regs.readDataA + dataReg;
  assign accAddr = (state == dataPathPkg::stReadRegs) ? sumAddr : wbAdr;

  // writeback for a write command or a good load
  assign regs.writeEnable = doneValid && !doneError &&
                            ((opReg == dataPathPkg::opWrite) || (opReg == dataPathPkg::opLoad));
  assign regs.writeAddr   = rdReg;
  assign regs.writeData   = (opReg == dataPathPkg::opWrite) ? dataReg : resultA;

  always_ff @(posedge gclk) begin
    if (reset) begin
      state     <= dataPathPkg::stIdle;
      wbCyc     <= 1'b0;
      wbStb     <= 1'b0;
      wbWe      <= 1'b0;
      doneError <= 1'b0;
    end else begin
      case (state)
        dataPathPkg::stIdle: begin
          if (cmdValid) begin
            doneError <= 1'b0;
            state <= (cmdOp == dataPathPkg::opWrite) ? dataPathPkg::stFinish
                                                     : dataPathPkg::stReadRegs;
          end
        end
        dataPathPkg::stReadRegs: begin
          if (opReg == dataPathPkg::opRead) begin
            state <= dataPathPkg::stFinish;
          end else if (misaligned) begin
            // never reaches the bus
            doneError <= 1'b1;
            state     <= dataPathPkg::stFinish;
          end else begin
            wbCyc <= 1'b1;
            wbStb <= 1'b1;
            wbWe  <= (opReg == dataPathPkg::opStore);
            state <= dataPathPkg::stBusCycle;
          end
        end
        dataPathPkg::stBusCycle: begin
          if (wbAck) begin
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
            wbWe  <= 1'b0;
            state <= dataPathPkg::stFinish;
          end
        end
        default: begin
          state <= dataPathPkg::stIdle;
        end
      endcase
    end
  end

  // command fields and bus payload
  always_ff @(posedge gclk) begin
    if (cmdReady && cmdValid) begin
      opReg   <= cmdOp;
      accSize <= cmdSize;
      rdReg   <= cmdRd;
      raReg   <= cmdRa;
      rbReg   <= cmdRb;
      dataReg <= cmdData;
    end
    if (state == dataPathPkg::stReadRegs) begin
      resultA  <= regs.readDataA;
      resultB  <= regs.readDataB;
      wbAdr    <= sumAddr;
      wbSel    <= storeSel;
      wbDatOut <= storeData;
    end
    if ((state == dataPathPkg::stBusCycle) && wbAck && (opReg == dataPathPkg::opLoad)) begin
      resultA <= loadData;
    end
  end

  stbInCyc: assert property (@(posedge gclk) disable iff (reset) wbStb |-> wbCyc);

  // bus request held until the slave answers
  wbHold: assert property (@(posedge gclk) disable iff (reset)
    (wbStb && !wbAck) |=> $stable({wbAdr, wbSel, wbDatOut, wbWe}));

endmodule

// ==== dataPathTop.sv ====
`include "dataPath_config.svh"

module dataPathTop (
  input  logic                  gclk,
  input  logic                  reset,
  input  logic                  cmdValid,
  input  dataPathPkg::cmdOp_t   cmdOp,
  input  dataPathPkg::accSize_t cmdSize,
  input  dataPathPkg::regAddr_t cmdRd,
  input  dataPathPkg::regAddr_t cmdRa,
  input  dataPathPkg::regAddr_t cmdRb,
  input  dataPathPkg::word_t    cmdData,
  output logic                  cmdReady,
  output logic                  doneValid,
  output logic                  doneError,
  output dataPathPkg::word_t    resultA,
  output dataPathPkg::word_t    resultB,
  output logic                  wbCyc,
  output logic                  wbStb,
  output logic                  wbWe,
  output dataPathPkg::word_t    wbAdr,
  output dataPathPkg::byteSel_t wbSel,
  output dataPathPkg::word_t    wbDatOut,
  input  dataPathPkg::word_t    wbDatIn,
  input  logic                  wbAck
);

  dataPathPkg::word_t    storeData;
  dataPathPkg::byteSel_t storeSel;
  logic                  misaligned;
  dataPathPkg::word_t    loadData;
  dataPathPkg::word_t    accAddr;
  dataPathPkg::accSize_t accSize;

  regPortIf regsBus ();

  regFile regFile_inst (
    .gclk  (gclk),
    .reset (reset),
    .regs  (regsBus)
  );

  loadAlign loadAlign_inst (
    .dataIn  (wbDatIn),
    .addrLow (accAddr[1:0]),
    .size    (accSize),
    .dataOut (loadData)
  );

  // store source comes straight from read port D
  storeAlign storeAlign_inst (
    .dataIn     (regsBus.readDataD),
    .addrLow    (accAddr[1:0]),
    .size       (accSize),
    .dataOut    (storeData),
    .byteSel    (storeSel),
    .misaligned (misaligned)
  );

  dataPathControl dataPathControl_inst (
    .*,
    .regs (regsBus)
  );

endmodule

// ==== dataPathTb.sv ====
module dataPathTb;

  logic gclk = 1'b0;
  logic reset;
  logic cmdValid;
  dataPathPkg::cmdOp_t cmdOp;
  dataPathPkg::accSize_t cmdSize;
  dataPathPkg::regAddr_t cmdRd;
  dataPathPkg::regAddr_t cmdRa;
  dataPathPkg::regAddr_t cmdRb;
  dataPathPkg::word_t cmdData;
  logic cmdReady;
  logic doneValid;
  logic doneError;
  dataPathPkg::word_t resultA;
  dataPathPkg::word_t resultB;
  logic wbCyc;
  logic wbStb;
  logic wbWe;
  dataPathPkg::word_t wbAdr;
  dataPathPkg::byteSel_t wbSel;
  dataPathPkg::word_t wbDatOut;
  dataPathPkg::word_t wbDatIn = '0;
  logic wbAck = 1'b0;

  // memory model state
  dataPathPkg::word_t mem [256];
  int fillIdx;
  int lane;
  int waitLeft;
  logic busBusy;
  logic [7:0] memIdx;

  // one entry per line of the test data
  string nameQ[$];
  string opQ[$];
  int sizeQ[$];
  int rdQ[$];
  int raQ[$];
  int rbQ[$];
  dataPathPkg::word_t dataQ[$];
  dataPathPkg::word_t expAQ[$];
  dataPathPkg::word_t expBQ[$];
  logic errQ[$];

  int cycleCount = 0;
  int cycleLimit = 0;
  int errorCount = 0;
  int testsPassed = 0;
  int testsFailed = 0;
  logic doneSeen;
  logic sawCyc;
  logic gotErr;
  logic fileOk;
  dataPathPkg::word_t gotA;
  dataPathPkg::word_t gotB;

  dataPathTop dataPathTop_inst (.*);

  always #5 gclk = ~gclk;

  always @(posedge gclk) begin
    cycleCount++;
    if ((cycleLimit > 0) && (cycleCount >= cycleLimit)) begin
      $display("timeout after %0d cycles, the tests did not finish", cycleCount);
      $display("Simulation failed");
      $finish;
    end
  end

  // Wishbone slave, 256 words, 0 to 3 wait cycles per access
  always @(posedge gclk) begin
    if (reset) begin
      for (fillIdx = 0; fillIdx < 256; fillIdx++) begin
        mem[fillIdx[7:0]] = 32'h5EED0000 ^ (fillIdx * 32'h00010003);
      end
      busBusy = 1'b0;
      #1;
      wbAck = 1'b0;
    end else if (wbCyc && wbStb && !wbAck) begin
      if (!busBusy) begin
        busBusy = 1'b1;
        waitLeft = int'($urandom % 4);
      end
      if (waitLeft == 0) begin
        busBusy = 1'b0;
        memIdx = wbAdr[9:2];
        if (wbWe) begin
          for (lane = 0; lane < 4; lane++) begin
            if (wbSel[lane[1:0]]) begin
              mem[memIdx][{lane[1:0], 3'b000} +: 8] = wbDatOut[{lane[1:0], 3'b000} +: 8];
            end
          end
        end
        #1;
        wbDatIn = mem[memIdx];
        wbAck = 1'b1;
      end else begin
        waitLeft--;
      end
    end else begin
      #1;
      wbAck = 1'b0;
    end
  end

  function automatic dataPathPkg::cmdOp_t opFromName(input string name);
    dataPathPkg::cmdOp_t op;
    if (name == "write") begin
      op = dataPathPkg::opWrite;
    end else if (name == "read") begin
      op = dataPathPkg::opRead;
    end else if (name == "store") begin
      op = dataPathPkg::opStore;
    end else begin
      op = dataPathPkg::opLoad;
    end
    return op;
  endfunction

  task automatic reportMismatch(input string sigName, input dataPathPkg::word_t expected,
                                input dataPathPkg::word_t actual);
    $display("FAILED at %0t: %s expected %h, got %h", $time, sigName, expected, actual);
    errorCount++;
  endtask

  task automatic reportProblem(input string what);
    $display("error at %0t: %s", $time, what);
    errorCount++;
  endtask

  task automatic driveCommand(input dataPathPkg::cmdOp_t op, input int size, input int rd,
                              input int ra, input int rb, input dataPathPkg::word_t data);
    cmdOp = op;
    cmdSize = dataPathPkg::accSize_t'(size[1:0]);
    cmdRd = dataPathPkg::regAddr_t'(rd);
    cmdRa = dataPathPkg::regAddr_t'(ra);
    cmdRb = dataPathPkg::regAddr_t'(rb);
    cmdData = data;
    cmdValid = 1'b1;
  endtask

  // returns one time unit after the accepting edge
  task automatic waitAccept();
    int n;
    logic accepted;
    accepted = 1'b0;
    n = 0;
    while (!accepted && (n < 40)) begin
      if (cmdReady) begin
        accepted = 1'b1;
      end
      @(posedge gclk);
      #1;
      n++;
    end
    cmdValid = 1'b0;
    if (!accepted) begin
      reportProblem("command was not accepted within 40 cycles");
    end
  endtask

  task automatic waitDone(input logic holdCheck);
    int n;
    doneSeen = 1'b0;
    sawCyc = 1'b0;
    n = 0;
    while (!doneSeen && (n < 40)) begin
      if (wbCyc) begin
        sawCyc = 1'b1;
      end
      if (doneValid) begin
        doneSeen = 1'b1;
        gotA = resultA;
        gotB = resultB;
        gotErr = doneError;
      end else begin
        if (holdCheck && cmdReady) begin
          reportProblem("cmdReady went high while a load was waiting for ack");
        end
        @(posedge gclk);
        #1;
        n++;
      end
    end
    if (!doneSeen) begin
      reportProblem("no doneValid within 40 cycles");
    end
  endtask

  task automatic readTestFile(output logic ok);
    int fd;
    int code;
    int sizeV;
    int rdV;
    int raV;
    int rbV;
    int errV;
    logic stop;
    string tok;
    string opName;
    string rest;
    dataPathPkg::word_t dataV;
    dataPathPkg::word_t expAV;
    dataPathPkg::word_t expBV;
    ok = 1'b0;
    stop = 1'b0;
    fd = $fopen("dataPathTestdata.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!stop) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) begin
          stop = 1'b1;
        end else if (tok[0] == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%s %d %d %d %d %h %h %h %d", opName, sizeV, rdV, raV, rbV,
                         dataV, expAV, expBV, errV);
          if (code != 9) begin
            $display("malformed test data line starting with %s", tok);
            ok = 1'b0;
            stop = 1'b1;
          end else begin
            nameQ.push_back(tok);
            opQ.push_back(opName);
            sizeQ.push_back(sizeV);
            rdQ.push_back(rdV);
            raQ.push_back(raV);
            rbQ.push_back(rbV);
            dataQ.push_back(dataV);
            expAQ.push_back(expAV);
            expBQ.push_back(expBV);
            errQ.push_back(errV != 0);
          end
        end
      end
      $fclose(fd);
      if (nameQ.size() == 0) begin
        ok = 1'b0;
      end
    end
  endtask

  task automatic runTest(input int i);
    int errorsBefore;
    string op;
    errorsBefore = errorCount;
    op = opQ[i];
    if (op == "memchk") begin
      if (mem[dataQ[i][9:2]] !== expAQ[i]) begin
        reportMismatch("memory word", expAQ[i], mem[dataQ[i][9:2]]);
      end
    end else begin
      driveCommand(opFromName(op), sizeQ[i], rdQ[i], raQ[i], rbQ[i], dataQ[i]);
      waitAccept();
      if (op == "loadhold") begin
        // read of the load target, held valid behind the load
        driveCommand(dataPathPkg::opRead, 2, 0, rdQ[i], 0, '0);
      end
      waitDone(op == "loadhold");
      if (doneSeen) begin
        if (gotErr !== errQ[i]) begin
          reportMismatch("doneError", dataPathPkg::word_t'(errQ[i]), dataPathPkg::word_t'(gotErr));
        end
        if ((op == "read") && (gotA !== expAQ[i])) begin
          reportMismatch("resultA", expAQ[i], gotA);
        end
        if ((op == "read") && (gotB !== expBQ[i])) begin
          reportMismatch("resultB", expBQ[i], gotB);
        end
        if (((op == "load") || (op == "loadhold")) && !errQ[i] && (gotA !== expAQ[i])) begin
          reportMismatch("resultA", expAQ[i], gotA);
        end
        if (errQ[i] && sawCyc) begin
          reportProblem("wbCyc went high for a misaligned access");
        end
        if ((op == "loadhold") && !sawCyc) begin
          reportProblem("held load finished without a bus cycle");
        end
      end
      if (op == "loadhold") begin
        waitAccept();
        waitDone(1'b0);
        if (doneSeen && (gotA !== expAQ[i])) begin
          reportMismatch("resultA of held read", expAQ[i], gotA);
        end
      end
    end
    if (errorCount == errorsBefore) begin
      testsPassed++;
      $display("test %-10s ok", nameQ[i]);
    end else begin
      testsFailed++;
      $display("test %-10s failed", nameQ[i]);
    end
  endtask

  initial begin
    reset = 1'b1;
    cmdValid = 1'b0;
    cmdOp = dataPathPkg::opWrite;
    cmdSize = dataPathPkg::sizeWord;
    cmdRd = '0;
    cmdRa = '0;
    cmdRb = '0;
    cmdData = '0;
    void'($urandom(85));
    readTestFile(fileOk);
    if (!fileOk) begin
      $display("could not read the commands from dataPathTestdata.txt");
      $display("Simulation failed");
      $finish;
    end else begin
      cycleLimit = nameQ.size() * 10 + 100;
      repeat (10) @(posedge gclk);
      #1;
      reset = 1'b0;
      @(posedge gclk);
      #1;
      for (int i = 0; i < nameQ.size(); i++) begin
        runTest(i);
      end
      $display("%0d tests, %0d passed, %0d failed, %0d errors",
               nameQ.size(), testsPassed, testsFailed, errorCount);
      if ((testsFailed == 0) && (errorCount == 0)) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

// ==== dataPathTestdata.txt ====
# name op size rd ra rb data expA expB expErr (data and expected values in hex)
# size 0 byte, 1 half, 2 word; memchk compares the memory word at address data with expA
wrBase     write    2 1  0 0  00000100 00000000 00000000 0
wrR2       write    2 2  0 0  cafef00d 00000000 00000000 0
wrR3       write    2 3  0 0  12345678 00000000 00000000 0
wrR0       write    2 0  0 0  ffffffff 00000000 00000000 0
wrR5       write    2 5  0 0  777777ab 00000000 00000000 0
wrR6       write    2 6  0 0  5555beef 00000000 00000000 0
wrR11      write    2 11 0 0  0badc0de 00000000 00000000 0
rdR1R2     read     2 0  1 2  00000000 00000100 cafef00d 0
rdR3R0     read     2 0  3 0  00000000 12345678 00000000 0
stWord     store    2 2  1 0  00000008 00000000 00000000 0
memWord    memchk   2 0  0 0  00000108 cafef00d 00000000 0
ldWord     load     2 4  1 0  00000008 cafef00d 00000000 0
stNeg      store    2 3  1 0  fffffffc 00000000 00000000 0
memNeg     memchk   2 0  0 0  000000fc 12345678 00000000 0
ldNeg      load     2 9  1 0  fffffffc 12345678 00000000 0
stBase     store    2 3  1 0  0000000c 00000000 00000000 0
stByte     store    0 5  1 0  0000000d 00000000 00000000 0
memByte    memchk   2 0  0 0  0000010c 1234ab78 00000000 0
stHalf     store    1 6  1 0  0000000e 00000000 00000000 0
memHalf    memchk   2 0  0 0  0000010c beefab78 00000000 0
ldB0       load     0 7  1 0  0000000c 00000078 00000000 0
ldB1       load     0 7  1 0  0000000d 000000ab 00000000 0
ldB2       load     0 7  1 0  0000000e 000000ef 00000000 0
ldB3       load     0 7  1 0  0000000f 000000be 00000000 0
ldH0       load     1 8  1 0  0000000c 0000ab78 00000000 0
ldH1       load     1 8  1 0  0000000e 0000beef 00000000 0
rdR7R8     read     2 0  7 8  00000000 000000be 0000beef 0
ldRep1     load     2 10 1 0  00000008 cafef00d 00000000 0
ldRep2     load     2 10 1 0  0000000c beefab78 00000000 0
ldRep3     load     0 10 1 0  0000000d 000000ab 00000000 0
ldMisHalf  load     1 11 1 0  00000009 00000000 00000000 1
ldMisWord  load     2 11 1 0  0000000a 00000000 00000000 1
stMisHalf  store    1 6  1 0  0000000b 00000000 00000000 1
stMisWord  store    2 3  1 0  00000009 00000000 00000000 1
memMis     memchk   2 0  0 0  00000108 cafef00d 00000000 0
rdR11      read     2 0  11 0 00000000 0badc0de 00000000 0
ldHold     loadhold 2 12 1 0  0000000c beefab78 00000000 0

// ==== vlog.f ====
+incdir+.
dataPathPkg.sv
regPortIf.sv
regFile.sv
loadAlign.sv
storeAlign.sv
dataPathControl.sv
dataPathTop.sv
dataPathTb.sv

// ==== runSim.sh ====
#!/bin/sh
# compile and run the data path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module dataPathTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

simOutput=$(./obj_dir/VdataPathTb)
simStatus=$?
printf '%s\n' "$simOutput"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if printf '%s\n' "$simOutput" | grep -q '^Simulation passed$'; then
  exit 0
else
  exit 1
fi
